//--- source/stat_pkg.sv
package stat_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths and register map
    ////////////////////////////////////////////////////////////////////////////
    localparam int STAT_DATA_WIDTH = 32;
    localparam int LEVEL_WIDTH = 16;
    localparam int STAT_ADDR_WIDTH = 30;
    localparam int REG_INDEX_WIDTH = 8;
    localparam int BLOCK_SEL_WIDTH = 4;
    localparam logic [BLOCK_SEL_WIDTH-1:0] TOP_BLOCK_SEL = '0;
    localparam logic [STAT_DATA_WIDTH-1:0] STAT_UNMAPPED_VALUE = 32'h345;
    localparam int NUM_STAT_REGS = 16;
    localparam int MAP_INDEX_WIDTH = $clog2(NUM_STAT_REGS);

    // Registers 0 to 12 count events, the last three hold max levels
    localparam int NUM_EVENT_REGS = 13;
    localparam int NUM_LEVEL_REGS = NUM_STAT_REGS - NUM_EVENT_REGS;

    // Packet class carried in the data-mover metadata
    typedef enum logic [1:0] {
        PKT_ETH,
        PKT_DROP,
        PKT_PCIE,
        PKT_OTHER
    } pkt_class_e;

    typedef enum logic [MAP_INDEX_WIDTH-1:0] {
        REG_IN_PKT,
        REG_META_IN,
        REG_PARSER_OUT,
        REG_FD_IN,
        REG_FD_OUT,
        REG_DM_IN,
        REG_CLASS_ETH,
        REG_CLASS_DROP,
        REG_CLASS_PCIE,
        REG_DM_PCIE_PKT,
        REG_DM_ETH_PKT,
        REG_OUT_PKT,
        REG_DMA_UPDATE,
        REG_MAX_PARSER_LVL,
        REG_MAX_FD_LVL,
        REG_MAX_DM2PCIE_LVL
    } stat_reg_e;

    ////////////////////////////////////////////////////////////////////////////
    // Tap and event bundles
    ////////////////////////////////////////////////////////////////////////////
    typedef struct packed {
        logic valid;
        logic ready;
        logic eop;
    } tap_t;

    typedef struct packed {
        tap_t       in_tap;
        tap_t       meta_in_tap;
        tap_t       parser_out_tap;
        tap_t       fd_in_tap;
        tap_t       fd_out_tap;
        tap_t       dm_in_tap;
        tap_t       dm_pcie_tap;
        tap_t       dm_eth_tap;
        tap_t       out_tap;
        pkt_class_e dm_in_class;
        logic       out_almost_full;
        logic       dma_update;
    } stat_taps_t;

    typedef struct packed {
        logic [LEVEL_WIDTH-1:0] parser_lvl;
        logic [LEVEL_WIDTH-1:0] fd_lvl;
        logic [LEVEL_WIDTH-1:0] dm2pcie_lvl;
    } stat_levels_t;

    // One strobe per counting register, in map order
    typedef struct packed {
        logic in_pkt;
        logic meta_in;
        logic parser_out;
        logic fd_in;
        logic fd_out;
        logic dm_in;
        logic class_eth;
        logic class_drop;
        logic class_pcie;
        logic dm_pcie_pkt;
        logic dm_eth_pkt;
        logic out_pkt;
        logic dma_update;
    } stat_events_t;

    typedef struct packed {
        logic                       read;
        logic [BLOCK_SEL_WIDTH-1:0] block_sel;
        logic [REG_INDEX_WIDTH-1:0] reg_index;
    } stat_req_t;

endpackage

//--- source/stat_event_decode.sv
`timescale 1ns/1ps

module stat_event_decode (
    input  logic                   clk_status,
    input  logic                   rst,
    input  stat_pkg::stat_taps_t   taps,
    input  stat_pkg::stat_levels_t levels,
    output stat_pkg::stat_events_t events,
    output stat_pkg::stat_levels_t levels_q
);

    stat_pkg::stat_events_t events_d;
    logic                   dm_in_fire;

    // Beat accepted on a valid/ready tap
    function automatic logic tap_fire(input stat_pkg::tap_t tap);
        return tap.valid & tap.ready;
    endfunction

    assign dm_in_fire = tap_fire(taps.dm_in_tap);

    always_comb begin
        // No back-pressure at the input, so ready is not looked at
        events_d.in_pkt      = taps.in_tap.valid & taps.in_tap.eop;
        events_d.meta_in     = tap_fire(taps.meta_in_tap);
        events_d.parser_out  = tap_fire(taps.parser_out_tap);
        events_d.fd_in       = tap_fire(taps.fd_in_tap);
        events_d.fd_out      = tap_fire(taps.fd_out_tap);
        events_d.dm_in       = dm_in_fire;

        // Class counters follow the data-mover metadata handshake
        events_d.class_eth   = dm_in_fire && (taps.dm_in_class == stat_pkg::PKT_ETH);
        events_d.class_drop  = dm_in_fire && (taps.dm_in_class == stat_pkg::PKT_DROP);
        events_d.class_pcie  = dm_in_fire && (taps.dm_in_class == stat_pkg::PKT_PCIE);

        events_d.dm_pcie_pkt = tap_fire(taps.dm_pcie_tap) & taps.dm_pcie_tap.eop;
        events_d.dm_eth_pkt  = tap_fire(taps.dm_eth_tap) & taps.dm_eth_tap.eop;
        events_d.out_pkt     = taps.out_tap.valid & taps.out_tap.eop & ~taps.out_almost_full;
        events_d.dma_update  = taps.dma_update;
    end

    always_ff @(posedge clk_status) begin
        if (rst) begin
            events <= '0;
        end else begin
            events <= events_d;
        end
    end

    // Levels take the same one-cycle delay as the strobes
    always_ff @(posedge clk_status) begin
        levels_q <= levels;
    end

endmodule

//--- source/stat_counter_bank.sv
`timescale 1ns/1ps

module stat_counter_bank (
    input  logic                   clk_status,
    input  logic                   rst,
    input  stat_pkg::stat_events_t events,
    input  stat_pkg::stat_levels_t levels_q,
    output logic [stat_pkg::NUM_STAT_REGS-1:0][stat_pkg::STAT_DATA_WIDTH-1:0] stat_values
);

    localparam int PAD_WIDTH = stat_pkg::STAT_DATA_WIDTH - stat_pkg::LEVEL_WIDTH;

    logic [stat_pkg::NUM_EVENT_REGS-1:0]                                event_vec;
    logic [stat_pkg::NUM_EVENT_REGS-1:0][stat_pkg::STAT_DATA_WIDTH-1:0] cnt_q;
    logic [stat_pkg::NUM_LEVEL_REGS-1:0][stat_pkg::STAT_DATA_WIDTH-1:0] lvl_ext;
    logic [stat_pkg::NUM_LEVEL_REGS-1:0][stat_pkg::STAT_DATA_WIDTH-1:0] max_q;

    ////////////////////////////////////////////////////////////////////////////
    // Strobes lined up by register index
    ////////////////////////////////////////////////////////////////////////////
    assign event_vec[stat_pkg::REG_IN_PKT]      = events.in_pkt;
    assign event_vec[stat_pkg::REG_META_IN]     = events.meta_in;
    assign event_vec[stat_pkg::REG_PARSER_OUT]  = events.parser_out;
    assign event_vec[stat_pkg::REG_FD_IN]       = events.fd_in;
    assign event_vec[stat_pkg::REG_FD_OUT]      = events.fd_out;
    assign event_vec[stat_pkg::REG_DM_IN]       = events.dm_in;
    assign event_vec[stat_pkg::REG_CLASS_ETH]   = events.class_eth;
    assign event_vec[stat_pkg::REG_CLASS_DROP]  = events.class_drop;
    assign event_vec[stat_pkg::REG_CLASS_PCIE]  = events.class_pcie;
    assign event_vec[stat_pkg::REG_DM_PCIE_PKT] = events.dm_pcie_pkt;
    assign event_vec[stat_pkg::REG_DM_ETH_PKT]  = events.dm_eth_pkt;
    assign event_vec[stat_pkg::REG_OUT_PKT]     = events.out_pkt;
    assign event_vec[stat_pkg::REG_DMA_UPDATE]  = events.dma_update;

    // Tracker slots 0..2: parser, flow director, dm2pcie
    assign lvl_ext[0] = {{PAD_WIDTH{1'b0}}, levels_q.parser_lvl};
    assign lvl_ext[1] = {{PAD_WIDTH{1'b0}}, levels_q.fd_lvl};
    assign lvl_ext[2] = {{PAD_WIDTH{1'b0}}, levels_q.dm2pcie_lvl};

    // Counters wrap naturally at 2^32
    always_ff @(posedge clk_status) begin
        if (rst) begin
            cnt_q <= '0;
            max_q <= '0;
        end else begin
            for (int i = 0; i < stat_pkg::NUM_EVENT_REGS; i++) begin
                if (event_vec[i]) begin
                    cnt_q[i] <= cnt_q[i] + 1'b1;
                end
            end
            for (int j = 0; j < stat_pkg::NUM_LEVEL_REGS; j++) begin
                if (lvl_ext[j] > max_q[j]) begin
                    max_q[j] <= lvl_ext[j];
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Output map
    ////////////////////////////////////////////////////////////////////////////
    for (genvar i = 0; i < stat_pkg::NUM_EVENT_REGS; i++) begin : g_cnt_out
        assign stat_values[i] = cnt_q[i];
    end

    assign stat_values[stat_pkg::REG_MAX_PARSER_LVL]  = max_q[0];
    assign stat_values[stat_pkg::REG_MAX_FD_LVL]      = max_q[1];
    assign stat_values[stat_pkg::REG_MAX_DM2PCIE_LVL] = max_q[2];

endmodule

//--- source/stat_read_port.sv
`timescale 1ns/1ps

module stat_read_port (
    input  logic                                 clk_status,
    input  logic                                 rst,
    input  logic [stat_pkg::STAT_ADDR_WIDTH-1:0] status_addr,
    input  logic                                 status_read,
    input  logic [stat_pkg::NUM_STAT_REGS-1:0][stat_pkg::STAT_DATA_WIDTH-1:0] stat_values,
    output logic [stat_pkg::STAT_DATA_WIDTH-1:0] status_readdata,
    output logic                                 status_readdata_valid
);

    stat_pkg::stat_req_t                  req_d;
    stat_pkg::stat_req_t                  req_q;
    logic                                 hit;
    logic [stat_pkg::STAT_DATA_WIDTH-1:0] rdata_d;

    // Block select on the top bits, register index on the low bits
    always_comb begin
        req_d.read      = status_read;
        req_d.block_sel = status_addr[stat_pkg::STAT_ADDR_WIDTH-1 -: stat_pkg::BLOCK_SEL_WIDTH];
        req_d.reg_index = status_addr[stat_pkg::REG_INDEX_WIDTH-1:0];
    end

    always_ff @(posedge clk_status) begin
        req_q <= req_d;
        if (rst) begin
            req_q.read <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Decode and answer
    ////////////////////////////////////////////////////////////////////////////
    assign hit = req_q.read && (req_q.block_sel == stat_pkg::TOP_BLOCK_SEL);

    always_comb begin
        if (req_q.reg_index < stat_pkg::NUM_STAT_REGS) begin
            rdata_d = stat_values[req_q.reg_index[stat_pkg::MAP_INDEX_WIDTH-1:0]];
        end else begin
            rdata_d = stat_pkg::STAT_UNMAPPED_VALUE;
        end
    end

    // Foreign block: no pulse at all
    always_ff @(posedge clk_status) begin
        if (rst) begin
            status_readdata_valid <= 1'b0;
        end else begin
            status_readdata_valid <= hit;
        end
    end

    always_ff @(posedge clk_status) begin
        if (hit) begin
            status_readdata <= rdata_d;
        end
    end

endmodule

//--- source/stat_top.sv
`timescale 1ns/1ps

module stat_top (
    input  logic                                 clk_status,
    input  logic                                 rst,
    input  stat_pkg::stat_taps_t                 taps,
    input  stat_pkg::stat_levels_t               levels,
    input  logic [stat_pkg::STAT_ADDR_WIDTH-1:0] status_addr,
    input  logic                                 status_read,
    output logic [stat_pkg::STAT_DATA_WIDTH-1:0] status_readdata,
    output logic                                 status_readdata_valid
);

    stat_pkg::stat_events_t events;
    stat_pkg::stat_levels_t levels_q;
    logic [stat_pkg::NUM_STAT_REGS-1:0][stat_pkg::STAT_DATA_WIDTH-1:0] stat_values;

    ////////////////////////////////////////////////////////////////////////////
    // Decode, count, read back
    ////////////////////////////////////////////////////////////////////////////
    stat_event_decode event_decode_i (
        .clk_status (clk_status),
        .rst        (rst),
        .taps       (taps),
        .levels     (levels),
        .events     (events),
        .levels_q   (levels_q)
    );

    stat_counter_bank counter_bank_i (
        .clk_status  (clk_status),
        .rst         (rst),
        .events      (events),
        .levels_q    (levels_q),
        .stat_values (stat_values)
    );

    stat_read_port read_port_i (
        .clk_status            (clk_status),
        .rst                   (rst),
        .status_addr           (status_addr),
        .status_read           (status_read),
        .stat_values           (stat_values),
        .status_readdata       (status_readdata),
        .status_readdata_valid (status_readdata_valid)
    );

endmodule

//--- testbench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 8
) (
    output logic clk_status,
    output logic rst
);

    initial begin
        clk_status = 1'b0;
        forever #(PERIOD_NS / 2) clk_status = ~clk_status;
    end

    // Release just after an edge so nothing samples it mid-change
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_status);
        #1 rst = 1'b0;
    end

endmodule

//--- testbench/tb_checker.sv
`timescale 1ns/1ps

module tb_checker #(
    parameter int TIMEOUT_CYCLES = 1000
) (
    input  logic                                 clk_status,
    input  logic                                 rst,
    input  stat_pkg::stat_taps_t                 taps,
    input  stat_pkg::stat_levels_t               levels,
    input  logic [stat_pkg::STAT_ADDR_WIDTH-1:0] status_addr,
    input  logic                                 status_read,
    input  logic [stat_pkg::STAT_DATA_WIDTH-1:0] status_readdata,
    input  logic                                 status_readdata_valid,
    output int                                   check_count,
    output int                                   error_count,
    output int                                   pending,
    output logic                                 timed_out
);

    logic [stat_pkg::STAT_DATA_WIDTH-1:0] model_cnt [stat_pkg::NUM_STAT_REGS];
    logic [stat_pkg::STAT_DATA_WIDTH-1:0] got [stat_pkg::NUM_STAT_REGS];
    logic [stat_pkg::STAT_DATA_WIDTH-1:0] other_cnt;
    logic [stat_pkg::STAT_DATA_WIDTH-1:0] exp_value_q [$];
    int                                   exp_index_q [$];
    int                                   issued = 0;
    int                                   answered = 0;
    int                                   cycle_cnt = 0;
    logic                                 timeout_hit = 1'b0;

    assign pending   = issued - answered;
    assign timed_out = timeout_hit;

    task automatic bump(input int idx);
        model_cnt[idx] = model_cnt[idx] + 32'd1;
    endtask

    task automatic raise_max(input int idx, input logic [stat_pkg::LEVEL_WIDTH-1:0] lvl);
        logic [stat_pkg::STAT_DATA_WIDTH-1:0] ext;
        ext = {{(stat_pkg::STAT_DATA_WIDTH - stat_pkg::LEVEL_WIDTH){1'b0}}, lvl};
        if (ext > model_cnt[idx]) begin
            model_cnt[idx] = ext;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Reference model, inputs sampled on the rising edge
    ////////////////////////////////////////////////////////////////////////////
    always @(posedge clk_status) begin : model_update
        logic [stat_pkg::BLOCK_SEL_WIDTH-1:0] blk;
        int                                   idx;
        if (rst) begin
            for (int i = 0; i < stat_pkg::NUM_STAT_REGS; i++) begin
                model_cnt[i] = '0;
            end
            other_cnt = '0;
            issued    = 0;
        end else begin
            blk = status_addr[stat_pkg::STAT_ADDR_WIDTH-1 -: stat_pkg::BLOCK_SEL_WIDTH];
            idx = int'(status_addr[stat_pkg::REG_INDEX_WIDTH-1:0]);
            // Answer reflects everything sampled before this edge
            if (status_read && blk == stat_pkg::TOP_BLOCK_SEL) begin
                exp_index_q.push_back(idx);
                if (idx < stat_pkg::NUM_STAT_REGS) begin
                    exp_value_q.push_back(model_cnt[idx]);
                end else begin
                    exp_value_q.push_back(stat_pkg::STAT_UNMAPPED_VALUE);
                end
                issued = issued + 1;
            end
            if (taps.in_tap.valid && taps.in_tap.eop) bump(stat_pkg::REG_IN_PKT);
            if (taps.meta_in_tap.valid && taps.meta_in_tap.ready) bump(stat_pkg::REG_META_IN);
            if (taps.parser_out_tap.valid && taps.parser_out_tap.ready) begin
                bump(stat_pkg::REG_PARSER_OUT);
            end
            if (taps.fd_in_tap.valid && taps.fd_in_tap.ready) bump(stat_pkg::REG_FD_IN);
            if (taps.fd_out_tap.valid && taps.fd_out_tap.ready) bump(stat_pkg::REG_FD_OUT);
            if (taps.dm_in_tap.valid && taps.dm_in_tap.ready) begin
                bump(stat_pkg::REG_DM_IN);
                case (taps.dm_in_class)
                    stat_pkg::PKT_ETH:  bump(stat_pkg::REG_CLASS_ETH);
                    stat_pkg::PKT_DROP: bump(stat_pkg::REG_CLASS_DROP);
                    stat_pkg::PKT_PCIE: bump(stat_pkg::REG_CLASS_PCIE);
                    default:            other_cnt = other_cnt + 32'd1;
                endcase
            end
            if (taps.dm_pcie_tap.valid && taps.dm_pcie_tap.ready && taps.dm_pcie_tap.eop) begin
                bump(stat_pkg::REG_DM_PCIE_PKT);
            end
            if (taps.dm_eth_tap.valid && taps.dm_eth_tap.ready && taps.dm_eth_tap.eop) begin
                bump(stat_pkg::REG_DM_ETH_PKT);
            end
            if (taps.out_tap.valid && taps.out_tap.eop && !taps.out_almost_full) begin
                bump(stat_pkg::REG_OUT_PKT);
            end
            if (taps.dma_update) bump(stat_pkg::REG_DMA_UPDATE);
            raise_max(stat_pkg::REG_MAX_PARSER_LVL, levels.parser_lvl);
            raise_max(stat_pkg::REG_MAX_FD_LVL, levels.fd_lvl);
            raise_max(stat_pkg::REG_MAX_DM2PCIE_LVL, levels.dm2pcie_lvl);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Answers, sampled on the falling edge
    ////////////////////////////////////////////////////////////////////////////
    always @(negedge clk_status) begin : answer_check
        int                                   idx;
        logic [stat_pkg::STAT_DATA_WIDTH-1:0] exp_val;
        logic [stat_pkg::STAT_DATA_WIDTH-1:0] class_sum;
        if (rst) begin
            for (int i = 0; i < stat_pkg::NUM_STAT_REGS; i++) begin
                got[i] = '0;
            end
            check_count = 0;
            error_count = 0;
            answered    = 0;
        end else if (status_readdata_valid) begin
            if (exp_index_q.size() == 0) begin
                $display("ERROR: valid pulse on the status port with no read outstanding");
                error_count = error_count + 1;
            end else begin
                idx         = exp_index_q.pop_front();
                exp_val     = exp_value_q.pop_front();
                answered    = answered + 1;
                check_count = check_count + 1;
                if (status_readdata !== exp_val) begin
                    $display("CHECK FAILED status_readdata reg %0d: expected 0x%08h, got 0x%08h",
                             idx, exp_val, status_readdata);
                    error_count = error_count + 1;
                end
                if (idx < stat_pkg::NUM_STAT_REGS) begin
                    if (idx >= stat_pkg::REG_MAX_PARSER_LVL && status_readdata < got[idx]) begin
                        $display("CHECK FAILED status_readdata reg %0d: previous 0x%08h, got 0x%08h",
                                 idx, got[idx], status_readdata);
                        error_count = error_count + 1;
                    end
                    got[idx] = status_readdata;
                end
                // Classes come right after REG_DM_IN in a sweep
                if (idx == stat_pkg::REG_CLASS_PCIE) begin
                    class_sum = got[stat_pkg::REG_CLASS_ETH] + got[stat_pkg::REG_CLASS_DROP]
                              + got[stat_pkg::REG_CLASS_PCIE] + other_cnt;
                    check_count = check_count + 1;
                    if (class_sum !== got[stat_pkg::REG_DM_IN]) begin
                        $display("CHECK FAILED class_sum: expected 0x%08h, got 0x%08h",
                                 got[stat_pkg::REG_DM_IN], class_sum);
                        error_count = error_count + 1;
                    end
                end
            end
        end
    end

    always @(posedge clk_status) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("ERROR: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            timeout_hit <= 1'b1;
        end
    end

endmodule

//--- testbench/tb_top.sv
`timescale 1ns/1ps

module tb_top;

    localparam int RESET_CYCLES = 8;
    localparam int PHASE_CYCLES = 400;
    localparam int IDLE_CYCLES  = 4;
    localparam int NUM_READS    = 19;
    localparam int DRAIN_CYCLES = 6;
    localparam int DRIVE_DELAY  = 1;
    localparam int RUN_CYCLES   = RESET_CYCLES + 2 * PHASE_CYCLES
                                + 3 * (IDLE_CYCLES + NUM_READS + DRAIN_CYCLES);
    localparam logic [31:0] LFSR_SEED = 32'h50fe_e5e3;
    localparam logic [31:0] LFSR_POLY = 32'h8020_0003;

    logic                                 clk_status;
    logic                                 rst;
    stat_pkg::stat_taps_t                 taps;
    stat_pkg::stat_levels_t               levels;
    logic [stat_pkg::STAT_ADDR_WIDTH-1:0] status_addr;
    logic                                 status_read;
    logic [stat_pkg::STAT_DATA_WIDTH-1:0] status_readdata;
    logic                                 status_readdata_valid;
    int                                   check_count;
    int                                   error_count;
    int                                   pending;
    logic                                 timed_out;
    logic [31:0]                          lfsr_state;
    int                                   last_checks;
    int                                   last_errors;

    tb_clock_gen #(.PERIOD_NS(4), .RESET_CYCLES(RESET_CYCLES)) clock_gen_i (
        .clk_status (clk_status),
        .rst        (rst)
    );

    stat_top dut_i (
        .clk_status            (clk_status),
        .rst                   (rst),
        .taps                  (taps),
        .levels                (levels),
        .status_addr           (status_addr),
        .status_read           (status_read),
        .status_readdata       (status_readdata),
        .status_readdata_valid (status_readdata_valid)
    );

    tb_checker #(.TIMEOUT_CYCLES(2 * RUN_CYCLES)) checker_i (
        .clk_status            (clk_status),
        .rst                   (rst),
        .taps                  (taps),
        .levels                (levels),
        .status_addr           (status_addr),
        .status_read           (status_read),
        .status_readdata       (status_readdata),
        .status_readdata_valid (status_readdata_valid),
        .check_count           (check_count),
        .error_count           (error_count),
        .pending               (pending),
        .timed_out             (timed_out)
    );

    // Galois LFSR, one step per bit
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val        = {val[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ LFSR_POLY) : (lfsr_state >> 1);
        end
        return val;
    endfunction

    function automatic stat_pkg::tap_t random_tap();
        logic [31:0] r;
        r = random_bits(3);
        return r[2:0];
    endfunction

    function automatic logic [stat_pkg::STAT_ADDR_WIDTH-1:0] make_addr(
        input logic [stat_pkg::BLOCK_SEL_WIDTH-1:0] blk,
        input int                                   idx
    );
        logic [stat_pkg::STAT_ADDR_WIDTH-1:0] addr;
        addr = '0;
        addr[stat_pkg::STAT_ADDR_WIDTH-1 -: stat_pkg::BLOCK_SEL_WIDTH] = blk;
        addr[stat_pkg::REG_INDEX_WIDTH-1:0] = idx[stat_pkg::REG_INDEX_WIDTH-1:0];
        return addr;
    endfunction

    task automatic drive_idle();
        taps   = '0;
        levels = '0;
    endtask

    task automatic drive_random(input int lvl_bits);
        logic [31:0] r;
        taps.in_tap         = random_tap();
        taps.meta_in_tap    = random_tap();
        taps.parser_out_tap = random_tap();
        taps.fd_in_tap      = random_tap();
        taps.fd_out_tap     = random_tap();
        taps.dm_in_tap      = random_tap();
        taps.dm_pcie_tap    = random_tap();
        taps.dm_eth_tap     = random_tap();
        taps.out_tap        = random_tap();
        r = random_bits(2);
        taps.dm_in_class = stat_pkg::pkt_class_e'(r[1:0]);
        r = random_bits(1);
        taps.out_almost_full = r[0];
        r = random_bits(1);
        taps.dma_update = r[0];
        r = random_bits(lvl_bits);
        levels.parser_lvl = r[15:0];
        r = random_bits(lvl_bits);
        levels.fd_lvl = r[15:0];
        r = random_bits(lvl_bits);
        levels.dm2pcie_lvl = r[15:0];
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Read every index, then one foreign block read
    ////////////////////////////////////////////////////////////////////////////
    task automatic read_sweep();
        for (int i = 0; i < NUM_READS - 1; i++) begin
            @(posedge clk_status);
            #DRIVE_DELAY;
            status_read = 1'b1;
            status_addr = make_addr(stat_pkg::TOP_BLOCK_SEL, i);
        end
        @(posedge clk_status);
        #DRIVE_DELAY;
        status_addr = make_addr(4'h3, stat_pkg::REG_DM_IN);
        @(posedge clk_status);
        #DRIVE_DELAY;
        status_read = 1'b0;
        status_addr = '0;
        wait (pending == 0);
        // Room for a stray pulse from the foreign read
        repeat (DRAIN_CYCLES) @(posedge clk_status);
    endtask

    task automatic run_test(input string name, input int cycles, input int lvl_bits);
        repeat (cycles) begin
            @(posedge clk_status);
            #DRIVE_DELAY;
            drive_random(lvl_bits);
        end
        @(posedge clk_status);
        #DRIVE_DELAY;
        drive_idle();
        repeat (IDLE_CYCLES - 1) @(posedge clk_status);
        read_sweep();
        $display("test %s: %0d checks, %0d errors", name,
                 check_count - last_checks, error_count - last_errors);
        last_checks = check_count;
        last_errors = error_count;
    endtask

    initial begin
        drive_idle();
        status_addr = '0;
        status_read = 1'b0;
        lfsr_state  = LFSR_SEED;
        last_checks = 0;
        last_errors = 0;
        wait (rst == 1'b0);
        run_test("reset_reads", 0, 0);
        // Wider levels in the second phase so the maxima move up
        run_test("random_phase_1", PHASE_CYCLES, 9);
        run_test("random_phase_2", PHASE_CYCLES, 12);
        $display("total: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        wait (timed_out == 1'b1);
        $display("Something failed");
        $finish;
    end

endmodule

//--- project.f
source/stat_pkg.sv
source/stat_event_decode.sv
source/stat_counter_bank.sv
source/stat_read_port.sv
source/stat_top.sv
testbench/tb_clock_gen.sv
testbench/tb_checker.sv
testbench/tb_top.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and judge the log

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

if ! verilator --binary --timing -Wno-fatal --top-module tb_top -f project.f \
        --Mdir obj_dir -o tb_sim > "$BUILD_LOG" 2>&1; then
    cat "$BUILD_LOG"
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_sim > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Everything OK" "$SIM_LOG"; then
    exit 0
fi
exit 1
